// File: build.f
+incdir+src
src/core_pkg.sv
src/instr_queue.sv
src/decode_control.sv
src/exec_unit.sv
src/wb_issue.sv
src/core_top.sv
dv/core_sva.sv
dv/core_tb.sv

// File: dv/core_tb.sv
`default_nettype none

`include "core_cfg.svh"

module core_tb;

  import core_pkg::*;

  logic        clk = 1'b0;
  logic        reset;
  logic        instr_valid;
  logic [31:0] instr;
  logic        instr_credit;
  logic        wb_credit;
  logic        wb_valid, wb_write, wb_ovf;
  logic [4:0]  wb_dest;
  logic [31:0] wb_data;

  logic [31:0] ref_regs [`CORE_NREGS];
  logic [31:0] ref_mem [`CORE_DMEM_WORDS];
  logic [38:0] exp_q [$];            // {write, dest, data, ovf} in issue order
  logic [31:0] drv_seed = 32'd3;
  logic [31:0] cr_seed;
  int          cyc = 0;              // posedge count
  int          n_sent = 0, n_back = 0, n_recs = 0;
  int          errs = 0, timeouts = 0;
  int          owed = 0;             // records not yet credited back
  int          stall_until = 0;

  logic [5:0]  fn_tab [10] = '{fn_add, fn_addu, fn_sub, fn_subu, fn_and,
                                fn_or, fn_xor, fn_nor, fn_slt, fn_sltu};
  logic [31:0] directed [10] = '{
    {op_ori, 5'd1, 5'd1, 16'hffff},                   // r1 = 7fffffff
    {op_rtype, 5'd1, 5'd1, 5'd2, 5'd0, fn_add},       // signed overflow
    {op_addi, 5'd0, 5'd3, 16'h8001},                  // negative immediate
    {op_rtype, 5'd1, 5'd3, 5'd4, 5'd0, fn_sltu},
    {op_rtype, 5'd1, 5'd3, 5'd5, 5'd0, fn_slt},
    {6'h2b, 5'd0, 5'd1, 16'd8},                       // sw r1 to word 2
    {op_lbu, 5'd0, 5'd6, 16'd11},                     // top byte of that word
    {op_lhu, 5'd0, 5'd7, 16'd8},
    {op_rtype, 5'd2, 5'd0, 5'd5, 5'd0, fn_or},        // r2 kept its old value
    {6'h3f, 26'h0}                                    // not a supported opcode
  };

  core_top dut0 (
    .i_clk(clk), .i_reset(reset), .i_instr_valid(instr_valid), .i_instr(instr),
    .o_instr_credit(instr_credit), .i_wb_credit(wb_credit), .o_wb_valid(wb_valid),
    .o_wb_write(wb_write), .o_wb_dest(wb_dest), .o_wb_data(wb_data), .o_wb_ovf(wb_ovf)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (instr_credit) n_back <= n_back + 1;  // one upstream credit per pulse
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ISA-level model applied in send order which matches issue order
  function automatic logic [38:0] ref_model(input logic [31:0] ins);
    logic [5:0]  opc, fn;
    logic [4:0]  dst;
    logic [31:0] a, b, se, ze, r, w;
    logic        wr, ov;
    opc = ins[31:26];
    fn  = ins[5:0];
    a   = ref_regs[ins[25:21]];
    b   = ref_regs[ins[20:16]];
    se  = {{16{ins[15]}}, ins[15:0]};
    ze  = {16'h0, ins[15:0]};
    r   = '0;
    wr  = 1'b1;
    ov  = 1'b0;
    dst = ins[20:16];
    case (opc)
      op_rtype: begin
        dst = ins[15:11];
        case (fn)
          fn_add, fn_addu: r = a + b;
          fn_sub, fn_subu: r = a - b;
          fn_and:  r = a & b;
          fn_or:   r = a | b;
          fn_xor:  r = a ^ b;
          fn_nor:  r = ~(a | b);
          fn_slt:  r = {31'b0, $signed(a) < $signed(b)};
          fn_sltu: r = {31'b0, a < b};
          default: wr = 1'b0;
        endcase
        if (fn == fn_add) ov = (a[31] == b[31]) && (r[31] != a[31]);
        if (fn == fn_sub) ov = (a[31] != b[31]) && (r[31] != a[31]);
      end
      op_addi: begin
        r  = a + se;
        ov = (a[31] == se[31]) && (r[31] != a[31]);
      end
      op_addiu: r = a + se;
      op_slti:  r = {31'b0, $signed(a) < $signed(se)};
      op_sltiu: r = {31'b0, a < se};      // sign-extended then compared unsigned
      op_andi:  r = a & ze;
      op_ori:   r = a | ze;
      op_xori:  r = a ^ ze;
      op_lui:   r = {ins[15:0], 16'h0};
      op_lw, op_lbu, op_lhu: begin
        w = ref_mem[(a + se) >> 2 & 32'hf];
        r = a + se;
        if (opc == op_lw) r = w;
        else if (opc == op_lbu) r = (w >> {r[1:0], 3'b000}) & 32'hff;
        else r = (w >> {r[1], 4'b0000}) & 32'hffff;
      end
      default: begin
        wr = 1'b0;
        if (opc[5:3] == 3'b101) begin     // word store reports its address
          r = a + se;
          ref_mem[r[5:2]] = b;
        end
      end
    endcase
    if (ov) wr = 1'b0;
    if (wr && dst != 5'd0) ref_regs[dst] = r;
    return {wr, dst, r, ov};
  endfunction

  function automatic logic [31:0] pick_instr();
    logic [31:0] r, s;
    logic [4:0]  rs;
    logic [15:0] imm;
    logic [1:0]  lane;
    drv_seed = xorshift(drv_seed);
    r        = drv_seed;
    drv_seed = xorshift(drv_seed);
    s        = drv_seed;
    rs   = s[4] ? {2'b00, r[2:0]} : 5'd0;           // memory base often r0
    imm  = s[5] ? r[31:16] : {10'h0, r[12:9], 2'b00};
    lane = (s[13:12] == 2'd1) ? r[14:13] : {r[13], 1'b0};
    case (s[3:0])
      4'd0, 4'd1, 4'd2, 4'd3, 4'd4:
        return {op_rtype, 2'b00, r[2:0], 2'b00, r[5:3], 2'b00, r[8:6], 5'd0, fn_tab[s[11:8] % 10]};
      4'd5, 4'd6, 4'd7, 4'd8: return {3'b001, s[14:12], 2'b00, r[2:0], 2'b00, r[5:3], imm};
      4'd9, 4'd10: return {3'b101, s[14:12], rs, 2'b00, r[5:3], 10'h0, r[12:9], 2'b00};
      4'd11, 4'd12, 4'd13: begin
        if (s[13:12] == 2'd0) return {op_lw, rs, 2'b00, r[5:3], 10'h0, r[12:9], 2'b00};
        if (s[13:12] == 2'd1) return {op_lbu, rs, 2'b00, r[5:3], 10'h0, r[12:9], lane};
        return {op_lhu, rs, 2'b00, r[5:3], 10'h0, r[12:9], lane};
      end
      4'd14:   return {2'b11, s[15:12], r[25:0]};   // opcodes 0x30 and up
      default: return {6'h00, r[25:6], 3'b000, s[14:12]}; // funct the core lacks
    endcase
  endfunction

  task automatic send_instr(input logic [31:0] ins, input int gap);
    int waited;
    waited = 0;
    if (timeouts != 0) return;
    @(posedge clk);
    instr_valid <= 1'b0;
    repeat (gap) @(posedge clk);
    while (n_sent - n_back >= `CORE_IQ_DEPTH && waited < 500) begin
      @(posedge clk);
      waited++;
    end
    if (waited >= 500) begin
      timeouts++;
      $display("timeout at %0t: no upstream credit came back", $time);
    end else begin
      instr_valid <= 1'b1;
      instr       <= ins;
      n_sent++;
      exp_q.push_back(ref_model(ins));
    end
  endtask

  task automatic check_latency(input logic [31:0] ins);
    int acc, t_cred, t_rec, n;
    send_instr(ins, 0);
    acc    = cyc + 1;                  // edge that takes the instruction
    t_cred = -1;
    t_rec  = -1;
    n      = 0;
    while (t_rec < 0 && n < 20) begin
      @(posedge clk);
      instr_valid <= 1'b0;
      n++;
      if (instr_credit && t_cred < 0) t_cred = cyc - 1; // set at the previous edge
      if (wb_valid) t_rec = cyc - 1;
    end
    if (t_rec < 0) begin
      timeouts++;
      $display("timeout at %0t: the first record never came out", $time);
    end else begin
      assert (t_rec == acc + 2) else begin
        errs++;
        $display("ERR %0t o_wb_valid edge exp=%0d got=%0d", $time, acc + 2, t_rec);
      end
      assert (t_cred == acc + 1) else begin
        errs++;
        $display("ERR %0t o_instr_credit edge exp=%0d got=%0d", $time, acc + 1, t_cred);
      end
    end
  endtask

  // downstream agent returns credits after random delays
  always @(posedge clk) begin : credit_return
    int o;
    o       = owed + int'(wb_valid);
    cr_seed = xorshift(cr_seed);
    assert (o <= `CORE_WB_CREDITS) else begin
      errs++;
      $display("ERR %0t outstanding_records exp<=%0d got=%0d", $time, `CORE_WB_CREDITS, o);
    end
    wb_credit <= 1'b0;
    if (o > 0 && cyc >= stall_until && cr_seed[1:0] != 2'b00) begin
      wb_credit <= 1'b1;
      o--;
    end
    owed <= o;
  end

  always @(posedge clk) begin : compare_records
    logic [38:0] e;
    if (wb_valid) begin
      n_recs <= n_recs + 1;
      assert (exp_q.size() != 0) else begin
        errs++;
        $display("record at %0t came out with no instruction left to match", $time);
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        assert (wb_write == e[38]) else begin
          errs++;
          $display("ERR %0t o_wb_write exp=%0b got=%0b", $time, e[38], wb_write);
        end
        assert (!e[38] || wb_dest == e[37:33]) else begin
          errs++;
          $display("ERR %0t o_wb_dest exp=%0d got=%0d", $time, e[37:33], wb_dest);
        end
        assert (wb_data == e[32:1]) else begin
          errs++;
          $display("ERR %0t o_wb_data exp=%h got=%h", $time, e[32:1], wb_data);
        end
        assert (wb_ovf == e[0]) else begin
          errs++;
          $display("ERR %0t o_wb_ovf exp=%0b got=%0b", $time, e[0], wb_ovf);
        end
      end
    end
  end

  initial begin
    logic [31:0] ins;
    int          waited;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    wb_credit   = 1'b0;
    cr_seed     = xorshift(xorshift(drv_seed));
    for (int i = 0; i < `CORE_NREGS; i++) ref_regs[i] = '0;
    for (int i = 0; i < `CORE_DMEM_WORDS; i++) ref_mem[i] = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    check_latency({op_lui, 5'd0, 5'd1, 16'h7fff}); // lone instruction on an idle core
    foreach (directed[i]) send_instr(directed[i], 0);
    for (int i = 0; i < 300; i++) begin
      if (i == 150) stall_until <= cyc + 40; // downstream holds its credits a while
      ins = pick_instr();
      send_instr(ins, (i > 150 && i < 170) ? 0 : int'(drv_seed[31:30] == 2'b00));
    end
    @(posedge clk);
    instr_valid <= 1'b0;

    waited = 0;
    while (exp_q.size() != 0 && waited < 1000) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      timeouts++;
      $display("timeout at %0t: %0d records never came out", $time, exp_q.size());
    end
    repeat (5) @(posedge clk);            // catch any extra record
    assert (n_recs == n_sent) else begin
      errs++;
      $display("ERR %0t record_count exp=%0d got=%0d", $time, n_sent, n_recs);
    end

    $display("errors: %0d mismatches, %0d timeouts", errs, timeouts);
    if (errs == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/core_sva.sv
`default_nettype none

`include "core_cfg.svh"

module core_sva (
  input logic i_clk,
  input logic i_reset,
  input logic i_instr_valid,
  input logic i_q_pop,
  input logic i_instr_credit,
  input logic i_wb_valid,
  input logic i_wb_credit
);

  logic [3:0] iq_used;      // entries held in the queue
  logic [3:0] outstanding;  // records not yet credited back

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      iq_used     <= '0;
      outstanding <= '0;
    end else begin
      iq_used     <= iq_used + 4'(i_instr_valid) - 4'(i_q_pop);
      outstanding <= outstanding + 4'(i_wb_valid) - 4'(i_wb_credit);
    end
  end

  // a new record needs a free downstream credit
  a_wb_credit: assert property (@(posedge i_clk) disable iff (i_reset)
    i_wb_valid |-> outstanding < 4'(`CORE_WB_CREDITS))
    else $error("record issued with every downstream credit in use");

  a_iq_full: assert property (@(posedge i_clk) disable iff (i_reset)
    i_instr_valid |-> iq_used < 4'(`CORE_IQ_DEPTH))
    else $error("instruction pushed into a full queue");

  a_credit_pop: assert property (@(posedge i_clk) disable iff (i_reset)
    i_q_pop |=> i_instr_credit)
    else $error("queue pop gave no credit pulse");

  a_credit_src: assert property (@(posedge i_clk) disable iff (i_reset)
    i_instr_credit |-> $past(i_q_pop))
    else $error("credit pulse without a queue pop");

endmodule

bind core_top core_sva sva0 (
  .i_clk(i_clk), .i_reset(i_reset), .i_instr_valid(i_instr_valid), .i_q_pop(q_pop),
  .i_instr_credit(o_instr_credit), .i_wb_valid(o_wb_valid), .i_wb_credit(i_wb_credit)
);

`default_nettype wire

// File: src/core_top.sv
`default_nettype none

module core_top (
  input  logic        i_clk,
  input  logic        i_reset,
  input  logic        i_instr_valid,
  input  logic [31:0] i_instr,
  output logic        o_instr_credit,
  input  logic        i_wb_credit,
  output logic        o_wb_valid,
  output logic        o_wb_write,
  output logic [4:0]  o_wb_dest,
  output logic [31:0] o_wb_data,
  output logic        o_wb_ovf
);

  import core_pkg::*;

  logic        q_valid, q_pop, issue_ok;
  logic [31:0] q_instr;
  logic        regdst, regwrite, alusrc, memread;
  logic        memwrite, memtoreg, ovf_check, sign_ext;
  alu_op_e     alu_op;
  load_kind_e  load_kind;
  logic        ex_valid, ex_write, ex_ovf;
  logic [4:0]  ex_dest;
  logic [31:0] ex_data;

  instr_queue u_iq (
    .i_clk(i_clk), .i_reset(i_reset), .i_instr_valid(i_instr_valid), .i_instr(i_instr),
    .i_pop(q_pop), .o_valid(q_valid), .o_instr(q_instr), .o_credit(o_instr_credit)
  );

  decode_control u_dec ( // purely combinational on the queue head
    .i_instr(q_instr), .o_regdst(regdst), .o_regwrite(regwrite), .o_alusrc(alusrc),
    .o_memread(memread), .o_memwrite(memwrite), .o_memtoreg(memtoreg),
    .o_ovf_check(ovf_check), .o_sign_ext(sign_ext), .o_alu_op(alu_op),
    .o_load_kind(load_kind)
  );

  exec_unit u_ex (
    .i_clk(i_clk), .i_reset(i_reset), .i_q_valid(q_valid), .i_issue_ok(issue_ok),
    .i_instr(q_instr), .i_regdst(regdst), .i_regwrite(regwrite), .i_alusrc(alusrc),
    .i_memread(memread), .i_memwrite(memwrite), .i_memtoreg(memtoreg),
    .i_ovf_check(ovf_check), .i_sign_ext(sign_ext), .i_alu_op(alu_op),
    .i_load_kind(load_kind), .o_pop(q_pop), .o_valid(ex_valid), .o_write(ex_write),
    .o_dest(ex_dest), .o_data(ex_data), .o_ovf(ex_ovf)
  );

  wb_issue u_wb (
    .i_clk(i_clk), .i_reset(i_reset), .i_ex_valid(ex_valid), .i_ex_write(ex_write),
    .i_ex_dest(ex_dest), .i_ex_data(ex_data), .i_ex_ovf(ex_ovf), .i_wb_credit(i_wb_credit),
    .o_issue_ok(issue_ok), .o_wb_valid(o_wb_valid), .o_wb_write(o_wb_write),
    .o_wb_dest(o_wb_dest), .o_wb_data(o_wb_data), .o_wb_ovf(o_wb_ovf)
  );

endmodule

`default_nettype wire

// File: src/wb_issue.sv
`default_nettype none

module wb_issue (
  input  logic        i_clk,
  input  logic        i_reset,
  input  logic        i_ex_valid,
  input  logic        i_ex_write,
  input  logic [4:0]  i_ex_dest,
  input  logic [31:0] i_ex_data,
  input  logic        i_ex_ovf,
  input  logic        i_wb_credit,
  output logic        o_issue_ok,
  output logic        o_wb_valid,
  output logic        o_wb_write,
  output logic [4:0]  o_wb_dest,
  output logic [31:0] o_wb_data,
  output logic        o_wb_ovf
);

`include "core_cfg.svh"

  localparam int CW = $clog2(`CORE_WB_CREDITS + 1);

  logic [CW-1:0] credit_cnt;

  // a result sitting in exec already owns a credit not yet taken from the count
  assign o_issue_ok = (credit_cnt > CW'(i_ex_valid));

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      credit_cnt <= CW'(`CORE_WB_CREDITS);
      o_wb_valid <= 1'b0;
    end else begin
      credit_cnt <= credit_cnt - CW'(i_ex_valid) + CW'(i_wb_credit); // both may hit at once
      o_wb_valid <= i_ex_valid;                                       // one cycle per record
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ex_valid) begin
      o_wb_write <= i_ex_write;
      o_wb_dest  <= i_ex_dest;
      o_wb_data  <= i_ex_data;
      o_wb_ovf   <= i_ex_ovf;
    end
  end

endmodule

`default_nettype wire

// File: src/exec_unit.sv
`default_nettype none

module exec_unit (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  logic                 i_q_valid,
  input  logic                 i_issue_ok,
  input  logic [31:0]          i_instr,
  input  logic                 i_regdst,
  input  logic                 i_regwrite,
  input  logic                 i_alusrc,
  input  logic                 i_memread,
  input  logic                 i_memwrite,
  input  logic                 i_memtoreg,
  input  logic                 i_ovf_check,
  input  logic                 i_sign_ext,
  input  core_pkg::alu_op_e    i_alu_op,
  input  core_pkg::load_kind_e i_load_kind,
  output logic                 o_pop,
  output logic                 o_valid,
  output logic                 o_write,
  output logic [4:0]           o_dest,
  output logic [31:0]          o_data,
  output logic                 o_ovf
);

  import core_pkg::*;

`include "core_cfg.svh"

  localparam int XLEN = `CORE_XLEN;
  localparam int MAW = $clog2(`CORE_DMEM_WORDS);

  logic [XLEN-1:0] regs [`CORE_NREGS];
  logic [XLEN-1:0] dmem [`CORE_DMEM_WORDS];
  logic [4:0]      rs, rt, rd, dest;
  logic [XLEN-1:0] op_a, op_b, rt_val, imm_ext;
  logic [XLEN-1:0] sum, diff, alu_res;
  logic [XLEN-1:0] mem_word, load_data, wb_val;
  logic [MAW-1:0]  mem_idx;
  logic            ovf, issue, do_write;

  assign rs   = i_instr[25:21];
  assign rt   = i_instr[20:16];
  assign rd   = i_instr[15:11];
  assign dest = i_regdst ? rd : rt;

  assign op_a    = (rs == 5'd0) ? '0 : regs[rs]; // r0 hardwired to zero
  assign rt_val  = (rt == 5'd0) ? '0 : regs[rt];
  assign imm_ext = i_sign_ext ? {{16{i_instr[15]}}, i_instr[15:0]} : {16'b0, i_instr[15:0]};
  assign op_b    = i_alusrc ? imm_ext : rt_val;

  assign sum  = op_a + op_b;
  assign diff = op_a - op_b;

  always_comb begin
    case (i_alu_op)
      alu_add:  alu_res = sum;
      alu_sub:  alu_res = diff;
      alu_and:  alu_res = op_a & op_b;
      alu_or:   alu_res = op_a | op_b;
      alu_xor:  alu_res = op_a ^ op_b;
      alu_nor:  alu_res = ~(op_a | op_b);
      alu_slt:  alu_res = XLEN'($signed(op_a) < $signed(op_b));
      alu_sltu: alu_res = XLEN'(op_a < op_b);
      alu_lui:  alu_res = {i_instr[15:0], 16'b0};
      default:  alu_res = '0;
    endcase
  end

  // same-sign operands giving an opposite-sign result
  always_comb begin
    ovf = 1'b0;
    if (i_ovf_check) begin
      if (i_alu_op == alu_sub) ovf = (op_a[XLEN-1] != op_b[XLEN-1]) && (diff[XLEN-1] != op_a[XLEN-1]);
      else ovf = (op_a[XLEN-1] == op_b[XLEN-1]) && (sum[XLEN-1] != op_a[XLEN-1]);
    end
  end

  assign mem_idx  = alu_res[MAW+1:2]; // word index, low two bits pick the lane
  assign mem_word = dmem[mem_idx];

  always_comb begin
    case (i_load_kind)
      ld_byte_u: load_data = XLEN'(mem_word[{alu_res[1:0], 3'b000} +: 8]);
      ld_half_u: load_data = XLEN'(mem_word[{alu_res[1], 4'b0000} +: 16]);
      default:   load_data = mem_word;
    endcase
    if (!i_memread) load_data = '0;
  end

  assign wb_val   = i_memtoreg ? load_data : alu_res;
  assign do_write = i_regwrite && !ovf; // overflow drops the write
  assign issue    = i_q_valid && i_issue_ok;
  assign o_pop    = issue;

  // state updates land at the issue edge so the next issue sees them
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < `CORE_NREGS; i++) regs[i] <= '0;
      for (int j = 0; j < `CORE_DMEM_WORDS; j++) dmem[j] <= '0;
      o_valid <= 1'b0;
    end else begin
      o_valid <= issue;
      if (issue && do_write && dest != 5'd0) regs[dest] <= wb_val;
      if (issue && i_memwrite) dmem[mem_idx] <= rt_val;
    end
  end

  always_ff @(posedge i_clk) begin
    if (issue) begin
      o_write <= do_write;
      o_dest  <= dest;
      o_ovf   <= ovf;
      // stores report their address, unsupported ops report zero
      if (i_regwrite) o_data <= wb_val;
      else if (i_memwrite) o_data <= alu_res;
      else o_data <= '0;
    end
  end

endmodule

`default_nettype wire

// File: src/decode_control.sv
`default_nettype none

module decode_control (
  input  logic [31:0]          i_instr,
  output logic                 o_regdst,    // 1: dest is rd, 0: dest is rt
  output logic                 o_regwrite,
  output logic                 o_alusrc,    // 1: operand b is the immediate
  output logic                 o_memread,
  output logic                 o_memwrite,
  output logic                 o_memtoreg,  // write back memory data
  output logic                 o_ovf_check, // trap-free signed overflow detect
  output logic                 o_sign_ext,
  output core_pkg::alu_op_e    o_alu_op,
  output core_pkg::load_kind_e o_load_kind
);

  import core_pkg::*;

  logic [5:0] opcode;
  logic [5:0] funct;

  assign opcode = i_instr[31:26];
  assign funct  = i_instr[5:0];

  always_comb begin
    // everything off, so unknown opcodes do nothing
    o_regdst    = 1'b0;
    o_regwrite  = 1'b0;
    o_alusrc    = 1'b0;
    o_memread   = 1'b0;
    o_memwrite  = 1'b0;
    o_memtoreg  = 1'b0;
    o_ovf_check = 1'b0;
    o_sign_ext  = 1'b0;
    o_alu_op    = alu_add;
    o_load_kind = ld_word;

    casez (opcode)
      op_rtype: begin
        o_regdst   = 1'b1;
        o_regwrite = 1'b1;
        case (funct)
          fn_add: begin
            o_alu_op    = alu_add;
            o_ovf_check = 1'b1;
          end
          fn_addu: o_alu_op = alu_add;
          fn_sub: begin
            o_alu_op    = alu_sub;
            o_ovf_check = 1'b1;
          end
          fn_subu: o_alu_op = alu_sub;
          fn_and:  o_alu_op = alu_and;
          fn_or:   o_alu_op = alu_or;
          fn_xor:  o_alu_op = alu_xor;
          fn_nor:  o_alu_op = alu_nor;
          fn_slt:  o_alu_op = alu_slt;
          fn_sltu: o_alu_op = alu_sltu;
          default: begin             // unknown funct, treat as unsupported
            o_regdst   = 1'b0;
            o_regwrite = 1'b0;
          end
        endcase
      end
      op_addi: begin
        o_regwrite  = 1'b1;
        o_alusrc    = 1'b1;
        o_sign_ext  = 1'b1;
        o_ovf_check = 1'b1;
      end
      op_addiu, op_slti, op_sltiu: begin
        o_regwrite = 1'b1;
        o_alusrc   = 1'b1;
        o_sign_ext = 1'b1;           // sltiu still sign extends, then compares unsigned
        if (opcode == op_slti) o_alu_op = alu_slt;
        if (opcode == op_sltiu) o_alu_op = alu_sltu;
      end
      op_andi, op_ori, op_xori, op_lui: begin
        o_regwrite = 1'b1;
        o_alusrc   = 1'b1;           // zero-extended immediate
        case (opcode)
          op_andi: o_alu_op = alu_and;
          op_ori:  o_alu_op = alu_or;
          op_xori: o_alu_op = alu_xor;
          default: o_alu_op = alu_lui;
        endcase
      end
      op_lw, op_lbu, op_lhu: begin
        o_regwrite = 1'b1;
        o_alusrc   = 1'b1;
        o_memread  = 1'b1;
        o_memtoreg = 1'b1;
        o_sign_ext = 1'b1;           // base + signed offset
        if (opcode == op_lbu) o_load_kind = ld_byte_u;
        if (opcode == op_lhu) o_load_kind = ld_half_u;
      end
      6'b101???: begin               // any store is a word store
        o_alusrc   = 1'b1;
        o_memwrite = 1'b1;
        o_sign_ext = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: src/instr_queue.sv
`default_nettype none

module instr_queue (
  input  logic        i_clk,
  input  logic        i_reset,
  input  logic        i_instr_valid,
  input  logic [31:0] i_instr,
  input  logic        i_pop,
  output logic        o_valid,
  output logic [31:0] o_instr,
  output logic        o_credit
);

`include "core_cfg.svh"

  localparam int DEPTH = `CORE_IQ_DEPTH;
  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  logic [31:0]   mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          full;
  logic          push;
  logic          pop;

  assign full = (count == CW'(DEPTH));
  assign push = i_instr_valid && !full; // credits keep upstream off a full queue
  assign pop  = i_pop && o_valid;

  assign o_valid = (count != '0);
  assign o_instr = mem[rd_ptr];         // head entry shown combinationally

  // entry storage
  always_ff @(posedge i_clk) begin
    if (push) begin
      mem[wr_ptr] <= i_instr;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      o_credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count    <= count + CW'(push) - CW'(pop);
      o_credit <= pop;                  // one credit back per freed entry
    end
  end

endmodule

`default_nettype wire

// File: src/core_pkg.sv
`default_nettype none

package core_pkg;

  // main opcodes, stores are matched by the 101xxx pattern instead
  typedef enum logic [5:0] {
    op_rtype = 6'b000000,
    op_addi  = 6'b001000,
    op_addiu = 6'b001001,
    op_slti  = 6'b001010,
    op_sltiu = 6'b001011,
    op_andi  = 6'b001100,
    op_ori   = 6'b001101,
    op_xori  = 6'b001110,
    op_lui   = 6'b001111,
    op_lw    = 6'b100011,
    op_lbu   = 6'b100100,
    op_lhu   = 6'b100101
  } opcode_e;

  typedef enum logic [5:0] {
    fn_add  = 6'b100000,
    fn_addu = 6'b100001,
    fn_sub  = 6'b100010,
    fn_subu = 6'b100011,
    fn_and  = 6'b100100,
    fn_or   = 6'b100101,
    fn_xor  = 6'b100110,
    fn_nor  = 6'b100111,
    fn_slt  = 6'b101010,
    fn_sltu = 6'b101011
  } funct_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_nor, alu_slt, alu_sltu, alu_lui
  } alu_op_e;

  // zero-extended slices only, no signed sub-word loads
  typedef enum logic [1:0] {
    ld_word   = 2'b00,
    ld_half_u = 2'b01,
    ld_byte_u = 2'b10
  } load_kind_e;

endpackage

`default_nettype wire

// File: src/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// datapath width
`define CORE_XLEN 32

// instruction queue entries, also the credits upstream starts with
`define CORE_IQ_DEPTH 4

`define CORE_WB_CREDITS 2   // records allowed in flight downstream
`define CORE_DMEM_WORDS 16  // word index comes from address bits 5..2
`define CORE_NREGS 32

`endif
